/* flist.f */
hdl/msx_mem_pkg.sv
hdl/msx_slot_pkg.sv
hdl/subslot_select.sv
hdl/msx2_ram_mapper.sv
hdl/cart_rom_mapper.sv
hdl/msx_slots.sv
test/tb_clock_gen.sv
test/msx_slots_tb.sv

/* hdl/cart_rom_mapper.sv */
`timescale 1ns/10ps

module cart_rom_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clk_en,
   input  logic                   wr,
   input  msx_mem_pkg::cpu_addr_t cpu_addr,
   input  msx_mem_pkg::byte_t     cpu_dout,
   output msx_mem_pkg::mem_addr_t cart_addr,
   output logic                   mapped
);

   import msx_mem_pkg::*;

   byte_t       bank_reg [4];
   logic        bank_wr;
   logic [1:0]  wr_idx;
   logic [1:0]  win_idx;
   byte_t       win_bank;
   logic [18:0] rom_offset;

   // ASCII8 bank registers live in 6000-7FFF, 2 KB apart
   assign bank_wr = clk_en && wr && (cpu_addr[15:13] == 3'b011);
   assign wr_idx  = cpu_addr[12:11];

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 4; i++) begin
            bank_reg[i] <= byte_t'(i);
         end
      end else if (bank_wr) begin
         bank_reg[wr_idx] <= cpu_dout;
      end
   end

   // 8 KB windows at 4000, 6000, 8000 and A000
   assign win_idx = 2'(cpu_addr[15:13] - 3'd2);
   assign mapped  = (cpu_addr[15:14] == 2'b01) || (cpu_addr[15:14] == 2'b10);

   assign win_bank   = bank_reg[win_idx];
   assign rom_offset = {win_bank[CART_BANK_BITS-1:0], cpu_addr[12:0]};

   assign cart_addr = CART_BASE + mem_addr_t'(rom_offset);

endmodule

/* hdl/msx2_ram_mapper.sv */
`timescale 1ns/10ps

module msx2_ram_mapper (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clk_en,
   input  msx_mem_pkg::cpu_addr_t cpu_addr,
   input  msx_mem_pkg::byte_t     cpu_dout,
   input  logic                   cpu_wr,
   input  logic                   cpu_rd,
   input  logic                   cpu_iorq,
   output msx_mem_pkg::ram_bank_t bank,
   output logic                   io_hit,
   output msx_mem_pkg::byte_t     rdata
);

   import msx_mem_pkg::*;
   import msx_slot_pkg::*;

   // Bits above the implemented bank width read as 1
   localparam byte_t UNUSED_MASK = ~byte_t'((1 << RAM_BANK_BITS) - 1);

   ram_bank_t bank_reg [4];
   logic      port_sel;
   logic      port_wr;

   // Ports FC to FF, low address byte only
   assign port_sel = cpu_iorq && (cpu_addr[7:2] == MAPPER_PORT_BASE[7:2]);
   assign port_wr  = clk_en && cpu_wr && port_sel;
   assign io_hit   = port_sel && cpu_rd;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         // Pages 0 to 3 start on banks 3 to 0
         for (int i = 0; i < 4; i++) begin
            bank_reg[i] <= ram_bank_t'(3 - i);
         end
      end else if (port_wr) begin
         bank_reg[cpu_addr[1:0]] <= cpu_dout;
      end
   end

   // Bank for the page being accessed
   assign bank = bank_reg[cpu_addr[15:14]];

   assign rdata = bank_reg[cpu_addr[1:0]] | UNUSED_MASK;

   // An I/O cycle on the mapper ports is either a read or a write
   a_port_rd_wr_excl: assert property (
      @(posedge clk) disable iff (reset)
      port_sel |-> !(cpu_rd && cpu_wr)
   ) else $error("mapper port read and written in the same cycle");

endmodule

/* hdl/msx_mem_pkg.sv */
package msx_mem_pkg;

   // Data and address widths
   typedef logic [7:0]  byte_t;
   typedef logic [15:0] cpu_addr_t;
   typedef logic [21:0] mem_addr_t;

   // Mapper bank index, as written through the I/O ports
   typedef logic [7:0]  ram_bank_t;

   // One of the four 16 KB pages of the CPU space
   typedef logic [1:0]  page_t;

   // SDRAM layout
   localparam mem_addr_t BIOS_BASE = 22'h000000;
   localparam mem_addr_t RAM_BASE  = 22'h040000;
   localparam mem_addr_t CART_BASE = 22'h100000;

   // 16 banks of 16 KB
   localparam int RAM_BANK_BITS  = 4;

   // 64 banks of 8 KB
   localparam int CART_BANK_BITS = 6;

endpackage

/* hdl/msx_slot_pkg.sv */
package msx_slot_pkg;

   typedef enum logic [2:0] {
      EMPTY,
      ROM,
      MSX2_RAM,
      CART,
      EXPANDED
   } slot_typ_t;

   // Slot layout, indexed [level][slot][page]
   // Level 0 holds the primary slots, level 1 the subslots of the expanded slot
   localparam slot_typ_t SLOT_LAYOUT [2][4][4] = '{
      '{
         '{ROM,      ROM,      EMPTY,    EMPTY},
         '{CART,     CART,     CART,     CART},
         '{EMPTY,    EMPTY,    EMPTY,    EMPTY},
         '{EXPANDED, EXPANDED, EXPANDED, EXPANDED}
      },
      '{
         '{ROM,      ROM,      EMPTY,    EMPTY},
         '{EMPTY,    EMPTY,    EMPTY,    EMPTY},
         '{MSX2_RAM, MSX2_RAM, MSX2_RAM, MSX2_RAM},
         '{EMPTY,    EMPTY,    EMPTY,    EMPTY}
      }
   };

   // ROM base per slot, same indexing without the page
   // Extension ROM follows the 32 KB main BIOS
   localparam msx_mem_pkg::mem_addr_t SLOT_ROM_BASE [2][4] = '{
      '{msx_mem_pkg::BIOS_BASE, '0, '0, '0},
      '{msx_mem_pkg::BIOS_BASE + 22'h008000, '0, '0, '0}
   };

   // Subslot register in the expanded slot
   localparam msx_mem_pkg::cpu_addr_t SUBSLOT_ADDR = 16'hFFFF;

   // Mapper ports FC to FF
   localparam msx_mem_pkg::byte_t MAPPER_PORT_BASE = 8'hFC;

   localparam logic [1:0] EXPANDED_SLOT = 2'd3;

endpackage

/* hdl/msx_slots.sv */
`timescale 1ns/10ps

module msx_slots (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clk_en,
   input  logic [1:0]             active_slot,
   // CPU bus
   input  msx_mem_pkg::cpu_addr_t cpu_addr,
   input  msx_mem_pkg::byte_t     cpu_dout,
   output msx_mem_pkg::byte_t     cpu_din,
   input  logic                   cpu_wr,
   input  logic                   cpu_rd,
   input  logic                   cpu_mreq,
   input  logic                   cpu_iorq,
   // SDRAM
   output msx_mem_pkg::mem_addr_t sdram_addr,
   output msx_mem_pkg::byte_t     sdram_din,
   output logic                   sdram_we,
   output logic                   sdram_rd,
   input  msx_mem_pkg::byte_t     sdram_dout
);

   import msx_mem_pkg::*;
   import msx_slot_pkg::*;

   page_t     page;
   page_t     page_subslot;
   slot_typ_t prim_typ;
   slot_typ_t eff_typ;
   logic      expanded;
   mem_addr_t rom_base;

   logic      mem_rd;
   logic      mem_wr;
   logic      subslot_wr;
   logic      subslot_hit;
   logic      subslot_acc;
   byte_t     subslot_rdata;

   ram_bank_t ram_bank;
   logic      mapper_hit;
   byte_t     mapper_rdata;

   logic      cart_wr;
   logic      cart_mapped;
   mem_addr_t cart_addr;

   logic      mem_sel;

   assign page   = cpu_addr[15:14];
   assign mem_rd = cpu_rd && cpu_mreq;
   assign mem_wr = cpu_wr && cpu_mreq;

   // Slot type lookup, going one level down in the expanded slot
   assign prim_typ = SLOT_LAYOUT[0][active_slot][page];
   assign expanded = (prim_typ == EXPANDED);

   always_comb begin
      if (expanded) begin
         eff_typ  = SLOT_LAYOUT[1][page_subslot][page];
         rom_base = SLOT_ROM_BASE[1][page_subslot];
      end else begin
         eff_typ  = prim_typ;
         rom_base = SLOT_ROM_BASE[0][active_slot];
      end
   end

   // Subslot register, only in the expanded slot
   assign subslot_wr = mem_wr && (active_slot == EXPANDED_SLOT);

   subslot_select subslot_select_i (
      .clk          (clk),
      .reset        (reset),
      .clk_en       (clk_en),
      .wr           (subslot_wr),
      .cpu_addr     (cpu_addr),
      .wdata        (cpu_dout),
      .page_subslot (page_subslot),
      .reg_hit      (subslot_hit),
      .rdata        (subslot_rdata)
   );

   // FFFF in slot 3 is the register, not memory
   assign subslot_acc = cpu_mreq && expanded && subslot_hit;

   msx2_ram_mapper msx2_ram_mapper_i (
      .clk      (clk),
      .reset    (reset),
      .clk_en   (clk_en),
      .cpu_addr (cpu_addr),
      .cpu_dout (cpu_dout),
      .cpu_wr   (cpu_wr),
      .cpu_rd   (cpu_rd),
      .cpu_iorq (cpu_iorq),
      .bank     (ram_bank),
      .io_hit   (mapper_hit),
      .rdata    (mapper_rdata)
   );

   assign cart_wr = mem_wr && (eff_typ == CART);

   cart_rom_mapper cart_rom_mapper_i (
      .clk       (clk),
      .reset     (reset),
      .clk_en    (clk_en),
      .wr        (cart_wr),
      .cpu_addr  (cpu_addr),
      .cpu_dout  (cpu_dout),
      .cart_addr (cart_addr),
      .mapped    (cart_mapped)
   );

   always_comb begin
      case (eff_typ)
         ROM:      sdram_addr = rom_base + mem_addr_t'(cpu_addr);
         MSX2_RAM: sdram_addr = RAM_BASE
                              + mem_addr_t'({ram_bank[RAM_BANK_BITS-1:0], cpu_addr[13:0]});
         CART:     sdram_addr = cart_addr;
         default:  sdram_addr = '0;
      endcase
   end

   // Memory cycle that lands in ROM, RAM or a live cartridge window
   assign mem_sel = cpu_mreq && !subslot_acc
                 && ((eff_typ == ROM) || (eff_typ == MSX2_RAM)
                     || ((eff_typ == CART) && cart_mapped));

   assign sdram_din = cpu_dout;
   assign sdram_we  = mem_wr && (eff_typ == MSX2_RAM) && !subslot_hit;
   assign sdram_rd  = mem_rd && mem_sel;

   always_comb begin
      if (mapper_hit) begin
         cpu_din = mapper_rdata;
      end else if (subslot_acc) begin
         cpu_din = subslot_rdata;
      end else if (mem_sel) begin
         cpu_din = sdram_dout;
      end else begin
         cpu_din = 8'hFF;
      end
   end

   a_no_rd_and_we: assert property (
      @(posedge clk) disable iff (reset)
      !(sdram_we && sdram_rd)
   ) else $error("SDRAM read and write strobes high together");

endmodule

/* hdl/subslot_select.sv */
`timescale 1ns/10ps

module subslot_select (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   clk_en,
   input  logic                   wr,
   input  msx_mem_pkg::cpu_addr_t cpu_addr,
   input  msx_mem_pkg::byte_t     wdata,
   output msx_mem_pkg::page_t     page_subslot,
   output logic                   reg_hit,
   output msx_mem_pkg::byte_t     rdata
);

   import msx_mem_pkg::*;
   import msx_slot_pkg::*;

   // Two bits per page, page 0 in the low bits
   byte_t subslot_reg;
   logic  reg_wr;

   assign reg_hit = (cpu_addr == SUBSLOT_ADDR);
   assign reg_wr  = clk_en && wr && reg_hit;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         subslot_reg <= '0;
      end else if (reg_wr) begin
         subslot_reg <= wdata;
      end
   end

   always_comb begin
      case (cpu_addr[15:14])
         2'd0:    page_subslot = subslot_reg[1:0];
         2'd1:    page_subslot = subslot_reg[3:2];
         2'd2:    page_subslot = subslot_reg[5:4];
         default: page_subslot = subslot_reg[7:6];
      endcase
   end

   // MSX reads the register back inverted
   assign rdata = ~subslot_reg;

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module msx_slots_tb -o msx_slots_sim

output=$(./obj_dir/msx_slots_sim)
echo "$output"

if echo "$output" | grep -q "^Simulation PASSED$"; then
   exit 0
else
   exit 1
fi

/* test/msx_slots_input.txt */
# test op en slot addr data exp_addr we rd din  (op 0 idle, 1 mem rd, 2 mem wr, 3 io rd, 4 io wr)
# exp_addr is checked only when we or rd is 1, din only on reads; SDRAM data is addr[7:0]^addr[15:8]
1 1 1 0 0000 00 000000 0 1 00
1 1 1 0 7FFF 00 007FFF 0 1 80
1 1 1 0 8000 00 000000 0 0 FF
1 1 1 0 C000 00 000000 0 0 FF
1 1 1 2 4000 00 000000 0 0 FF
1 0 1 0 0000 00 000000 0 0 00
2 1 1 3 FFFF 00 000000 0 0 FF
2 1 1 3 0100 00 008100 0 1 81
2 2 1 3 FFFF 20 000000 0 0 00
2 1 1 3 FFFF 00 000000 0 0 DF
2 1 1 3 8000 00 044000 0 1 40
2 1 1 3 8123 00 044123 0 1 62
2 2 1 3 FFFF A0 000000 0 0 00
2 1 1 3 FFFF 00 000000 0 0 5F
2 1 1 3 C010 00 040010 0 1 10
2 2 1 3 FFFF 20 000000 0 0 00
2 1 1 3 FFFF 00 000000 0 0 DF
3 3 1 0 00FC 00 000000 0 0 F3
3 3 1 0 00FD 00 000000 0 0 F2
3 3 1 0 00FE 00 000000 0 0 F1
3 3 1 0 12FF 00 000000 0 0 F0
3 4 1 0 00FE 05 000000 0 0 00
3 3 1 0 00FE 00 000000 0 0 F5
3 2 1 3 8123 AA 054123 1 0 00
3 3 1 0 00FB 00 000000 0 0 FF
3 0 1 3 8123 00 000000 0 0 00
4 2 1 1 6800 07 000000 0 0 00
4 1 1 1 6010 00 10E010 0 1 F0
4 1 1 1 4000 00 100000 0 1 00
4 1 1 1 A010 00 106010 0 1 70
4 2 1 1 7800 3F 000000 0 0 00
4 1 1 1 A000 00 17E000 0 1 E0
4 1 1 1 0000 00 000000 0 0 FF
4 1 1 1 C000 00 000000 0 0 FF
5 2 1 0 0000 55 000000 0 0 00
5 2 1 0 7FFF 55 000000 0 0 00
5 2 1 3 0100 55 000000 0 0 00
5 2 1 2 4000 55 000000 0 0 00
5 4 0 0 00FC 09 000000 0 0 00
5 3 1 0 00FC 00 000000 0 0 F3
5 2 0 3 FFFF 00 000000 0 0 00
5 1 1 3 FFFF 00 000000 0 0 DF
5 2 0 1 6000 11 000000 0 0 00
5 1 1 1 4000 00 100000 0 1 00
5 0 1 1 4000 00 000000 0 0 00

/* test/msx_slots_tb.sv */
`timescale 1ns/10ps

module msx_slots_tb;

   import msx_mem_pkg::*;

   localparam string VECTOR_FILE  = "test/msx_slots_input.txt";
   localparam int    SAMPLE_DELAY = 4;

   localparam int OP_IDLE   = 0;
   localparam int OP_MEM_RD = 1;
   localparam int OP_MEM_WR = 2;
   localparam int OP_IO_RD  = 3;
   localparam int OP_IO_WR  = 4;

   logic       clk;
   logic       reset;
   logic       clk_en;
   logic [1:0] active_slot;
   cpu_addr_t  cpu_addr;
   byte_t      cpu_dout;
   byte_t      cpu_din;
   logic       cpu_wr;
   logic       cpu_rd;
   logic       cpu_mreq;
   logic       cpu_iorq;
   mem_addr_t  sdram_addr;
   byte_t      sdram_din;
   logic       sdram_we;
   logic       sdram_rd;
   byte_t      sdram_dout;

   // One entry per bus cycle
   int         vec_test [$];
   int         vec_op [$];
   logic       vec_en [$];
   logic [1:0] vec_slot [$];
   cpu_addr_t  vec_addr [$];
   byte_t      vec_data [$];
   mem_addr_t  vec_exp_addr [$];
   logic       vec_exp_we [$];
   logic       vec_exp_rd [$];
   byte_t      vec_exp_din [$];

   int errors       = 0;
   int load_errors  = 0;
   int checks       = 0;
   int tests_run    = 0;
   int vectors_run  = 0;
   int test_vectors = 0;
   int test_errors  = 0;
   int cur_test     = 0;
   int cycle_count  = 0;
   int cycle_limit  = 50;

   tb_clock_gen clock_gen_i (
      .clk   (clk),
      .reset (reset)
   );

   msx_slots dut_i (
      .clk         (clk),
      .reset       (reset),
      .clk_en      (clk_en),
      .active_slot (active_slot),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .cpu_din     (cpu_din),
      .cpu_wr      (cpu_wr),
      .cpu_rd      (cpu_rd),
      .cpu_mreq    (cpu_mreq),
      .cpu_iorq    (cpu_iorq),
      .sdram_addr  (sdram_addr),
      .sdram_din   (sdram_din),
      .sdram_we    (sdram_we),
      .sdram_rd    (sdram_rd),
      .sdram_dout  (sdram_dout)
   );

   // SDRAM model answers in the same cycle
   assign sdram_dout = sdram_addr[7:0] ^ sdram_addr[15:8];

   task automatic load_vectors();
      int         fd;
      int         fields;
      int         line_no;
      string      line;
      int         t_test;
      int         t_op;
      logic       t_en;
      logic [1:0] t_slot;
      cpu_addr_t  t_addr;
      byte_t      t_data;
      mem_addr_t  t_exp_addr;
      logic       t_we;
      logic       t_rd;
      byte_t      t_din;
      line_no = 0;
      fd = $fopen(VECTOR_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the vector file %s", VECTOR_FILE);
         load_errors++;
      end else begin
         while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() > 1 && line[0] != "#") begin
               fields = $sscanf(line, "%d %d %d %d %h %h %h %d %d %h", t_test, t_op, t_en,
                                t_slot, t_addr, t_data, t_exp_addr, t_we, t_rd, t_din);
               if (fields == 10) begin
                  vec_test.push_back(t_test);
                  vec_op.push_back(t_op);
                  vec_en.push_back(t_en);
                  vec_slot.push_back(t_slot);
                  vec_addr.push_back(t_addr);
                  vec_data.push_back(t_data);
                  vec_exp_addr.push_back(t_exp_addr);
                  vec_exp_we.push_back(t_we);
                  vec_exp_rd.push_back(t_rd);
                  vec_exp_din.push_back(t_din);
               end else begin
                  $display("Vector file line %0d has %0d of 10 fields", line_no, fields);
                  load_errors++;
               end
            end
         end
         $fclose(fd);
         if (vec_test.size() == 0) begin
            $display("The vector file %s holds no vectors", VECTOR_FILE);
            load_errors++;
         end
      end
   endtask

   task automatic drive_vector(input int i);
      clk_en      = vec_en[i];
      active_slot = vec_slot[i];
      cpu_addr    = vec_addr[i];
      cpu_rd      = (vec_op[i] == OP_MEM_RD) || (vec_op[i] == OP_IO_RD);
      cpu_wr      = (vec_op[i] == OP_MEM_WR) || (vec_op[i] == OP_IO_WR);
      cpu_mreq    = (vec_op[i] == OP_MEM_RD) || (vec_op[i] == OP_MEM_WR);
      cpu_iorq    = (vec_op[i] == OP_IO_RD) || (vec_op[i] == OP_IO_WR);
      if (vec_op[i] == OP_IDLE) begin
         cpu_dout = byte_t'($urandom);
      end else begin
         cpu_dout = vec_data[i];
      end
   endtask

   task automatic report_mismatch(input int i, input string msg);
      $display("Fail at %0t: test %0d vector %0d, %s", $time, vec_test[i], i, msg);
      errors++;
      test_errors++;
   endtask

   task automatic check_vector(input int i);
      checks++;
      assert (sdram_we === vec_exp_we[i])
         else report_mismatch(i, $sformatf("sdram_we is %b, expected %b",
                                            sdram_we, vec_exp_we[i]));
      checks++;
      assert (sdram_rd === vec_exp_rd[i])
         else report_mismatch(i, $sformatf("sdram_rd is %b, expected %b",
                                            sdram_rd, vec_exp_rd[i]));
      // Address only matters while a strobe is up
      if (vec_exp_we[i] || vec_exp_rd[i]) begin
         checks++;
         assert (sdram_addr === vec_exp_addr[i])
            else report_mismatch(i, $sformatf("sdram_addr is %h, expected %h",
                                               sdram_addr, vec_exp_addr[i]));
      end
      if (vec_exp_we[i]) begin
         checks++;
         assert (sdram_din === vec_data[i])
            else report_mismatch(i, $sformatf("sdram_din is %h, expected %h",
                                               sdram_din, vec_data[i]));
      end
      if (vec_op[i] == OP_MEM_RD || vec_op[i] == OP_IO_RD) begin
         checks++;
         assert (cpu_din === vec_exp_din[i])
            else report_mismatch(i, $sformatf("cpu_din is %h, expected %h",
                                               cpu_din, vec_exp_din[i]));
      end
   endtask

   task automatic finish_test();
      $display("Test %0d finished: %0d vectors, %0d mismatches",
               cur_test, test_vectors, test_errors);
      tests_run++;
      test_vectors = 0;
      test_errors  = 0;
   endtask

   task automatic run_vectors();
      cur_test = vec_test[0];
      for (int i = 0; i < vec_test.size(); i++) begin
         if (vec_test[i] != cur_test) begin
            finish_test();
            cur_test = vec_test[i];
         end
         @(negedge clk);
         drive_vector(i);
         // Sample just ahead of the next rising edge
         #(SAMPLE_DELAY);
         check_vector(i);
         test_vectors++;
         vectors_run++;
      end
      finish_test();
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         $display("Run stopped after %0d cycles, the limit for %0d vectors",
                  cycle_count, vec_test.size());
         $display("Simulation FAILED");
         $finish;
      end
   end

   initial begin
      clk_en      = 1'b0;
      active_slot = 2'd0;
      cpu_addr    = '0;
      cpu_dout    = '0;
      cpu_wr      = 1'b0;
      cpu_rd      = 1'b0;
      cpu_mreq    = 1'b0;
      cpu_iorq    = 1'b0;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(39));
      load_vectors();
      if (load_errors == 0) begin
         cycle_limit = 4 * vec_test.size() + 50;
         wait (reset == 1'b0);
         run_vectors();
         $display("Tests run: %0d, vectors: %0d, checks: %0d, errors: %0d",
                  tests_run, vectors_run, checks, errors);
      end
      if (errors == 0 && load_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int PERIOD       = 10,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset drops on a falling edge
   initial begin
      reset = 1'b1;
      #(PERIOD * RESET_CYCLES) reset = 1'b0;
   end

endmodule
